// ==== list.f ====
hdl/rp_types_pkg.sv
hdl/rp_regmap_pkg.sv
hdl/rp_adc_capture.sv
hdl/rp_dac_mixer.sv
hdl/rp_sys_regs.sv
hdl/rp_sys_bus_decoder.sv
hdl/rp_analog_top.sv
tests/rp_analog_assert.sv
tests/rp_analog_checker.sv
tests/tb_rp_analog_top.sv

// ==== tests/tb_rp_analog_top.sv ====
/*
 * Testbench for the analog core. Random converter samples from a fixed
 * seed, bus accesses over all eight regions, then a loopback phase.
 */

`timescale 1ns/1ps

module tb_rp_analog_top;

  localparam int unsigned region_w = 20;

  // run length sets the timeout
  localparam int reset_cycles  = 16;
  localparam int sample_cycles = 2000;
  localparam int n_bus         = 20;
  localparam int loop_cycles   = 1000;
  localparam int settle_cycles = 50;
  localparam int seq_cycles    = reset_cycles + sample_cycles + loop_cycles
                                 + settle_cycles + (n_bus + 3) * 3;
  localparam int max_cycles    = (seq_cycles / 1000 + 1) * 1000; // next thousand up

  logic                      adc_clk;
  logic                      rst_n_i;
  rp_types_pkg::adc_sample_t adc_a_i;
  rp_types_pkg::adc_sample_t adc_b_i;
  rp_types_pkg::adc_sample_t asg_a_i;
  rp_types_pkg::adc_sample_t asg_b_i;
  rp_types_pkg::adc_sample_t pid_a_i;
  rp_types_pkg::adc_sample_t pid_b_i;
  rp_types_pkg::adc_sample_t adc_ch_a_o;
  rp_types_pkg::adc_sample_t adc_ch_b_o;
  rp_types_pkg::dac_code_t   dac_dat_a_o;
  rp_types_pkg::dac_code_t   dac_dat_b_o;
  logic                      dac_reset_o;
  rp_types_pkg::sys_addr_t   sys_addr_i;
  rp_types_pkg::sys_data_t   sys_wdata_i;
  logic                      sys_wen_i;
  logic                      sys_ren_i;
  rp_types_pkg::sys_data_t   sys_rdata_o;
  logic                      sys_ack_o;
  logic                      sys_err_o;

  int cycles       = 0;
  int bus_timeouts = 0; // accesses that never got an ack
  int total_errors;

  rp_analog_top #(
    .region_w (region_w)
  ) i_rp_analog_top (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_a_i     (adc_a_i),
    .adc_b_i     (adc_b_i),
    .asg_a_i     (asg_a_i),
    .asg_b_i     (asg_b_i),
    .pid_a_i     (pid_a_i),
    .pid_b_i     (pid_b_i),
    .adc_ch_a_o  (adc_ch_a_o),
    .adc_ch_b_o  (adc_ch_b_o),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_reset_o (dac_reset_o),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  rp_analog_checker #(
    .region_w (region_w)
  ) u_analog_checker (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_a_i     (adc_a_i),
    .adc_b_i     (adc_b_i),
    .asg_a_i     (asg_a_i),
    .asg_b_i     (asg_b_i),
    .pid_a_i     (pid_a_i),
    .pid_b_i     (pid_b_i),
    .adc_ch_a_o  (adc_ch_a_o),
    .adc_ch_b_o  (adc_ch_b_o),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_reset_o (dac_reset_o),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  // protocol assertions ride inside the dut
  bind rp_analog_top rp_analog_assert u_analog_assert (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .dac_reset_o (dac_reset_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk; // 50 MHz
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers driving on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  // fresh random samples over the full 14 bit range so sums saturate
  task automatic next_cycle();
    @(negedge adc_clk);
    adc_a_i = rp_types_pkg::adc_sample_t'($urandom);
    adc_b_i = rp_types_pkg::adc_sample_t'($urandom);
    asg_a_i = rp_types_pkg::adc_sample_t'($urandom);
    asg_b_i = rp_types_pkg::adc_sample_t'($urandom);
    pid_a_i = rp_types_pkg::adc_sample_t'($urandom);
    pid_b_i = rp_types_pkg::adc_sample_t'($urandom);
  endtask

  // one cycle strobe then wait for the ack
  task automatic bus_access(input logic wr, input rp_types_pkg::sys_addr_t addr,
                            input rp_types_pkg::sys_data_t data);
    int waited;
    waited      = 0;
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    next_cycle();
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    while (!sys_ack_o && waited < 4)
    begin
      next_cycle();
      waited++;
    end
    if (!sys_ack_o)
    begin
      $display("bus access to %h got no acknowledge", addr);
      bus_timeouts++;
    end
    next_cycle(); // idle gap between accesses
  endtask

  // picks an access of the given kind with random details
  task automatic random_access(input int kind);
    rp_types_pkg::sys_addr_t addr;
    rp_types_pkg::sys_data_t data;
    data = $urandom;
    case (kind)
      0: bus_access(1'b0, rp_regmap_pkg::id_ofs, data);
      1: bus_access(1'b1, rp_regmap_pkg::ctrl_ofs, data & ~32'h1); // loopback stays off
      2: bus_access(1'b0, rp_regmap_pkg::ctrl_ofs, data);
      3: bus_access(1'b0, rp_regmap_pkg::adc_ofs, data);
      4: bus_access(1'b1, rp_regmap_pkg::id_ofs, data); // read only
      5:
      begin
        addr = 32'h0C + 4 * $urandom_range(0, 1000); // unmapped offset
        bus_access($urandom_range(0, 1) == 1, addr, data);
      end
      default:
      begin
        addr = ($urandom_range(1, 7) << region_w) | ($urandom_range(0, 255) << 2);
        bus_access($urandom_range(0, 1) == 1, addr, data); // empty region
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(15253));
    rst_n_i     = 1'b0;
    adc_a_i     = '0;
    adc_b_i     = '0;
    asg_a_i     = '0;
    asg_b_i     = '0;
    pid_a_i     = '0;
    pid_b_i     = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    repeat (reset_cycles) @(negedge adc_clk);
    rst_n_i = 1'b1;

    repeat (sample_cycles) next_cycle(); // crossing and mixer with loopback off
    for (int i = 0; i < n_bus; i++)
      random_access(i % 7);

    bus_access(1'b1, rp_regmap_pkg::ctrl_ofs, 32'h1); // loopback on
    repeat (loop_cycles) next_cycle();
    bus_access(1'b0, rp_regmap_pkg::ctrl_ofs, '0);    // reads back 1
    bus_access(1'b1, rp_regmap_pkg::ctrl_ofs, '0);    // back to crossing
    repeat (settle_cycles) next_cycle();

    total_errors = u_analog_checker.data_errors + u_analog_checker.bus_errors
                   + i_rp_analog_top.u_analog_assert.assert_errors + bus_timeouts;
    $display("errors: data %0d, bus %0d, assertions %0d, ack timeouts %0d",
             u_analog_checker.data_errors, u_analog_checker.bus_errors,
             i_rp_analog_top.u_analog_assert.assert_errors, bus_timeouts);
    if (total_errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // watchdog
  always @(posedge adc_clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles)
    begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

endmodule

// ==== tests/rp_analog_checker.sv ====
/*
 * Reference model of the analog core. Tracks the sample pipelines, the
 * loopback bit and the bus responses, compares on every rising edge.
 */

`timescale 1ns/1ps

module rp_analog_checker #(
  parameter int unsigned region_w = 20
)(
  input logic                      adc_clk,
  input logic                      rst_n_i,
  input rp_types_pkg::adc_sample_t adc_a_i,
  input rp_types_pkg::adc_sample_t adc_b_i,
  input rp_types_pkg::adc_sample_t asg_a_i,
  input rp_types_pkg::adc_sample_t asg_b_i,
  input rp_types_pkg::adc_sample_t pid_a_i,
  input rp_types_pkg::adc_sample_t pid_b_i,
  input rp_types_pkg::adc_sample_t adc_ch_a_o,
  input rp_types_pkg::adc_sample_t adc_ch_b_o,
  input rp_types_pkg::dac_code_t   dac_dat_a_o,
  input rp_types_pkg::dac_code_t   dac_dat_b_o,
  input logic                      dac_reset_o,
  input rp_types_pkg::sys_addr_t   sys_addr_i,
  input rp_types_pkg::sys_data_t   sys_wdata_i,
  input logic                      sys_wen_i,
  input logic                      sys_ren_i,
  input rp_types_pkg::sys_data_t   sys_rdata_o,
  input logic                      sys_ack_o,
  input logic                      sys_err_o
);

  int data_errors = 0;
  int bus_errors  = 0;
  bit primed      = 1'b0; // outputs valid after the first reset edge

  rp_types_pkg::adc_sample_t raw_a;     // pin register
  rp_types_pkg::adc_sample_t raw_b;
  rp_types_pkg::adc_sample_t exp_ch_a;  // switch stage
  rp_types_pkg::adc_sample_t exp_ch_b;
  rp_types_pkg::dac_code_t   code_a_q;  // first dac stage
  rp_types_pkg::dac_code_t   code_b_q;
  rp_types_pkg::dac_code_t   exp_dat_a; // swapped stage
  rp_types_pkg::dac_code_t   exp_dat_b;
  logic                      exp_dac_reset;
  logic                      exp_loop;
  logic                      pend;      // ack due on next edge
  rp_types_pkg::sys_data_t   pend_data;
  logic                      pend_err;

  // clamp to the 14 bit range, negative slope dac wants it inverted
  function automatic rp_types_pkg::dac_code_t mix_code(input int asg, input int pid);
    int s;
    s = asg + pid;
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return ~rp_types_pkg::dac_code_t'(s);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual, input bit on_bus);
    if (actual !== expected)
    begin
      $display("Fail %s expected %h actual %h", name, expected, actual);
      if (on_bus)
        bus_errors++;
      else
        data_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare last edge's outputs, then step the model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge adc_clk)
  begin : model
    rp_types_pkg::dac_code_t                ca;
    rp_types_pkg::dac_code_t                cb;
    logic                                   loop_next;
    logic [$clog2(rp_regmap_pkg::n_regions)-1:0] region;
    rp_types_pkg::sys_addr_t                ofs;
    ca        = mix_code(asg_a_i, pid_a_i);
    cb        = mix_code(asg_b_i, pid_b_i);
    loop_next = exp_loop;
    if (primed)
    begin
      check_value("dac_reset", exp_dac_reset, dac_reset_o, 1'b0);
      check_value("adc_ch_a", exp_ch_a, adc_ch_a_o, 1'b0);
      check_value("adc_ch_b", exp_ch_b, adc_ch_b_o, 1'b0);
      check_value("dac_dat_a", exp_dat_a, dac_dat_a_o, 1'b0);
      check_value("dac_dat_b", exp_dat_b, dac_dat_b_o, 1'b0);
      if (pend)
      begin
        if (sys_ack_o !== 1'b1)
        begin
          $display("bus access got no acknowledge one cycle after its strobe");
          bus_errors++;
        end
        else
        begin
          check_value("bus_rdata", pend_data, sys_rdata_o, 1'b1);
          check_value("bus_err", pend_err, sys_err_o, 1'b1);
        end
      end
      else if (sys_ack_o !== 1'b0)
      begin
        $display("bus acknowledge seen without a pending access");
        bus_errors++;
      end
    end
    primed        = 1'b1;
    exp_dac_reset = !rst_n_i; // one cycle behind reset
    if (!rst_n_i)
    begin
      raw_a     = '0;
      raw_b     = '0;
      exp_ch_a  = '0;
      exp_ch_b  = '0;
      code_a_q  = '0;
      code_b_q  = '0;
      exp_dat_a = '0;
      exp_dat_b = '0;
      exp_loop  = 1'b0;
      pend      = 1'b0;
    end
    else
    begin
      // bus response, read data uses the channels as they stand now
      region    = sys_addr_i[region_w +: $clog2(rp_regmap_pkg::n_regions)];
      ofs       = rp_types_pkg::sys_addr_t'(sys_addr_i[region_w-1:0]);
      pend      = sys_wen_i || sys_ren_i;
      pend_data = '0;
      pend_err  = 1'b0;
      if (pend && region == rp_regmap_pkg::regs_region)
      begin
        if (sys_wen_i)
        begin
          if (ofs == rp_regmap_pkg::ctrl_ofs)
            loop_next = sys_wdata_i[0];
          else
            pend_err = 1'b1; // id is read only, rest unmapped
        end
        else if (ofs == rp_regmap_pkg::ctrl_ofs)
          pend_data = {31'd0, exp_loop};
        else if (ofs == rp_regmap_pkg::id_ofs)
          pend_data = rp_regmap_pkg::core_id;
        else if (ofs == rp_regmap_pkg::adc_ofs)
          pend_data = {16'(exp_ch_b), 16'(exp_ch_a)}; // sign extended halves
        else
          pend_err = 1'b1;
      end
      // adc switch uses the loop bit from before this edge
      if (exp_loop)
      begin
        exp_ch_a = ca;
        exp_ch_b = cb;
      end
      else
      begin
        exp_ch_a = {raw_b[13:2], 2'b00}; // crossed, lsbs cleared
        exp_ch_b = {raw_a[13:2], 2'b00};
      end
      raw_a     = adc_a_i;
      raw_b     = adc_b_i;
      exp_dat_a = code_b_q; // swap in second stage
      exp_dat_b = code_a_q;
      code_a_q  = ca;
      code_b_q  = cb;
      exp_loop  = loop_next;
    end
  end

endmodule

// ==== tests/rp_analog_assert.sv ====
/*
 * Bus handshake and DAC reset assertions, bound into the core top level.
 */

`timescale 1ns/1ps

module rp_analog_assert (
  input logic adc_clk,
  input logic rst_n_i,
  input logic sys_wen_i,
  input logic sys_ren_i,
  input logic sys_ack_o,
  input logic sys_err_o,
  input logic dac_reset_o
);

  int assert_errors = 0; // summed up by the testbench

  // ack exactly one cycle after a strobe
  a_ack_after_strobe: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (sys_wen_i || sys_ren_i) |=> sys_ack_o)
  else
  begin
    assert_errors++;
    $error("ack missing after strobe");
  end

  // and never without one
  a_no_stray_ack: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    !(sys_wen_i || sys_ren_i) |=> !sys_ack_o)
  else
  begin
    assert_errors++;
    $error("ack without strobe");
  end

  a_err_with_ack: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_err_o |-> sys_ack_o)
  else
  begin
    assert_errors++;
    $error("err outside ack");
  end

  // dac held in reset one cycle behind the core
  a_dac_reset: assert property (@(posedge adc_clk) !rst_n_i |=> dac_reset_o)
  else
  begin
    assert_errors++;
    $error("dac reset low after reset cycle");
  end

endmodule

// ==== hdl/rp_analog_top.sv ====
/*
 * Analog core top level. ADC capture with loopback, DAC mixer and the
 * system bus with its register block, all on adc_clk.
 */

`timescale 1ns/1ps

module rp_analog_top #(
  parameter int unsigned region_w = 20
)(
  input  logic                      adc_clk,
  input  logic                      rst_n_i,
  // converters
  input  rp_types_pkg::adc_sample_t adc_a_i,
  input  rp_types_pkg::adc_sample_t adc_b_i,
  input  rp_types_pkg::adc_sample_t asg_a_i,  // generator samples
  input  rp_types_pkg::adc_sample_t asg_b_i,
  input  rp_types_pkg::adc_sample_t pid_a_i,  // controller samples
  input  rp_types_pkg::adc_sample_t pid_b_i,
  output rp_types_pkg::adc_sample_t adc_ch_a_o,
  output rp_types_pkg::adc_sample_t adc_ch_b_o,
  output rp_types_pkg::dac_code_t   dac_dat_a_o,
  output rp_types_pkg::dac_code_t   dac_dat_b_o,
  output logic                      dac_reset_o,
  // system bus
  input  rp_types_pkg::sys_addr_t   sys_addr_i,
  input  rp_types_pkg::sys_data_t   sys_wdata_i,
  input  logic                      sys_wen_i,
  input  logic                      sys_ren_i,
  output rp_types_pkg::sys_data_t   sys_rdata_o,
  output logic                      sys_ack_o,
  output logic                      sys_err_o
);

  rp_types_pkg::dac_code_t dac_code_a;  // comb codes for loopback
  rp_types_pkg::dac_code_t dac_code_b;
  logic                    loop_en;
  rp_types_pkg::sys_addr_t reg_addr;
  rp_types_pkg::sys_data_t reg_wdata;
  rp_types_pkg::sys_data_t reg_rdata;
  logic                    reg_wen;
  logic                    reg_ren;
  logic                    reg_ack;
  logic                    reg_err;

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  rp_adc_capture i_adc_capture (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .adc_a_i      (adc_a_i),
    .adc_b_i      (adc_b_i),
    .dac_code_a_i (dac_code_a),
    .dac_code_b_i (dac_code_b),
    .loop_en_i    (loop_en),
    .adc_ch_a_o   (adc_ch_a_o),
    .adc_ch_b_o   (adc_ch_b_o)
  );

  rp_dac_mixer i_dac_mixer (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .asg_a_i      (asg_a_i),
    .asg_b_i      (asg_b_i),
    .pid_a_i      (pid_a_i),
    .pid_b_i      (pid_b_i),
    .dac_code_a_o (dac_code_a),
    .dac_code_b_o (dac_code_b),
    .dac_dat_a_o  (dac_dat_a_o),
    .dac_dat_b_o  (dac_dat_b_o),
    .dac_reset_o  (dac_reset_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // bus and registers
  ////////////////////////////////////////////////////////////////////////////

  rp_sys_bus_decoder #(
    .region_w (region_w)
  ) i_sys_bus_decoder (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .reg_rdata_i (reg_rdata),
    .reg_ack_i   (reg_ack),
    .reg_err_i   (reg_err),
    .reg_addr_o  (reg_addr),
    .reg_wdata_o (reg_wdata),
    .reg_wen_o   (reg_wen),
    .reg_ren_o   (reg_ren)
  );

  rp_sys_regs i_sys_regs (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_wen_i   (reg_wen),
    .reg_ren_i   (reg_ren),
    .adc_a_i     (adc_ch_a_o), // status shows switched channels
    .adc_b_i     (adc_ch_b_o),
    .reg_rdata_o (reg_rdata),
    .reg_ack_o   (reg_ack),
    .reg_err_o   (reg_err),
    .loop_en_o   (loop_en)
  );

endmodule

// ==== hdl/rp_sys_bus_decoder.sv ====
/*
 * System bus decoder. Splits the address space into eight regions, routes
 * region 0 to the register block and acks the empty ones itself.
 */

`timescale 1ns/1ps

module rp_sys_bus_decoder #(
  parameter int unsigned region_w = 20 // address bits inside a region
)(
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  // master side
  input  rp_types_pkg::sys_addr_t sys_addr_i,
  input  rp_types_pkg::sys_data_t sys_wdata_i,
  input  logic                    sys_wen_i,
  input  logic                    sys_ren_i,
  output rp_types_pkg::sys_data_t sys_rdata_o,
  output logic                    sys_ack_o,
  output logic                    sys_err_o,
  // register block side
  input  rp_types_pkg::sys_data_t reg_rdata_i,
  input  logic                    reg_ack_i,
  input  logic                    reg_err_i,
  output rp_types_pkg::sys_addr_t reg_addr_o,
  output rp_types_pkg::sys_data_t reg_wdata_o,
  output logic                    reg_wen_o,
  output logic                    reg_ren_o
);

  localparam int unsigned sel_w  = $clog2(rp_regmap_pkg::n_regions);
  localparam int unsigned addr_w = $bits(rp_types_pkg::sys_addr_t);

  logic [sel_w-1:0] region;    // index above the region offset
  logic             regs_hit;
  logic             stub_ack;  // empty regions answer here

  assign region   = sys_addr_i[region_w +: sel_w];
  assign regs_hit = (region == rp_regmap_pkg::regs_region);

  // strobes only reach the block in its own region
  assign reg_wen_o   = sys_wen_i & regs_hit;
  assign reg_ren_o   = sys_ren_i & regs_hit;
  assign reg_addr_o  = {{(addr_w-region_w){1'b0}}, sys_addr_i[region_w-1:0]};
  assign reg_wdata_o = sys_wdata_i;

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      stub_ack <= 1'b0;
    else
      stub_ack <= (sys_wen_i | sys_ren_i) & !regs_hit; // no data, no error
  end

  // response mux, only one source acks at a time
  assign sys_ack_o   = reg_ack_i | stub_ack;
  assign sys_err_o   = reg_ack_i & reg_err_i;
  assign sys_rdata_o = reg_ack_i ? reg_rdata_i : '0;

endmodule

// ==== hdl/rp_sys_regs.sv ====
/*
 * Register block in bus region 0. Holds the loopback switch, returns the
 * identification word and the switched ADC channels, flags bad accesses.
 */

`timescale 1ns/1ps

module rp_sys_regs (
  input  logic                      adc_clk,
  input  logic                      rst_n_i,
  input  rp_types_pkg::sys_addr_t   reg_addr_i,  // offset within region
  input  rp_types_pkg::sys_data_t   reg_wdata_i,
  input  logic                      reg_wen_i,   // one cycle strobe
  input  logic                      reg_ren_i,   // one cycle strobe
  input  rp_types_pkg::adc_sample_t adc_a_i,     // switched ch a
  input  rp_types_pkg::adc_sample_t adc_b_i,     // switched ch b
  output rp_types_pkg::sys_data_t   reg_rdata_o,
  output logic                      reg_ack_o,
  output logic                      reg_err_o,
  output logic                      loop_en_o
);

  rp_types_pkg::sys_data_t adc_stat; // both channels, sign extended

  assign adc_stat = {{2{adc_b_i[13]}}, adc_b_i, {2{adc_a_i[13]}}, adc_a_i};

  ////////////////////////////////////////////////////////////////////////////
  // access decode, answers on the edge after the strobe
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      reg_ack_o   <= 1'b0;
      reg_err_o   <= 1'b0;
      reg_rdata_o <= '0;
      loop_en_o   <= 1'b0;
    end
    else
    begin
      reg_ack_o   <= reg_wen_i | reg_ren_i;
      reg_err_o   <= 1'b0;
      reg_rdata_o <= '0; // zero unless a read hits
      if (reg_wen_i)
      begin
        case (reg_addr_i)
          rp_regmap_pkg::ctrl_ofs: loop_en_o <= reg_wdata_i[0];
          default:                 reg_err_o <= 1'b1; // read only or unmapped
        endcase
      end
      else if (reg_ren_i)
      begin
        case (reg_addr_i)
          rp_regmap_pkg::ctrl_ofs: reg_rdata_o <= {31'd0, loop_en_o};
          rp_regmap_pkg::id_ofs:   reg_rdata_o <= rp_regmap_pkg::core_id;
          rp_regmap_pkg::adc_ofs:  reg_rdata_o <= adc_stat; // sampled at strobe
          default:                 reg_err_o   <= 1'b1;
        endcase
      end
    end
  end

endmodule

// ==== hdl/rp_dac_mixer.sv ====
/*
 * DAC mixer. Adds generator and controller samples per channel, saturates
 * to 14 bits and inverts for the negative-slope DAC. Two register stages,
 * the second swaps the channels. Also drives the DAC reset.
 */

`timescale 1ns/1ps

module rp_dac_mixer (
  input  logic                      adc_clk,
  input  logic                      rst_n_i,
  input  rp_types_pkg::adc_sample_t asg_a_i,      // generator ch a
  input  rp_types_pkg::adc_sample_t asg_b_i,
  input  rp_types_pkg::adc_sample_t pid_a_i,      // controller ch a
  input  rp_types_pkg::adc_sample_t pid_b_i,
  output rp_types_pkg::dac_code_t   dac_code_a_o, // comb, to loopback
  output rp_types_pkg::dac_code_t   dac_code_b_o,
  output rp_types_pkg::dac_code_t   dac_dat_a_o,  // carries ch b
  output rp_types_pkg::dac_code_t   dac_dat_b_o,  // carries ch a
  output logic                      dac_reset_o
);

  rp_types_pkg::dac_sum_t  sum_a; // 15 bit, never overflows itself
  rp_types_pkg::dac_sum_t  sum_b;
  rp_types_pkg::dac_code_t dac_a_q;
  rp_types_pkg::dac_code_t dac_b_q;

  // clamp to -8192..8191 then invert for the neg slope
  function automatic rp_types_pkg::dac_code_t sat_inv(input rp_types_pkg::dac_sum_t sum);
    rp_types_pkg::dac_code_t sat;
    if (sum[14] ^ sum[13]) // top two bits differ, out of range
      sat = {sum[14], {13{~sum[14]}}};
    else
      sat = sum[13:0];
    return ~sat;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // sum and saturation
  ////////////////////////////////////////////////////////////////////////////

  assign sum_a = rp_types_pkg::dac_sum_t'(asg_a_i) + rp_types_pkg::dac_sum_t'(pid_a_i);
  assign sum_b = rp_types_pkg::dac_sum_t'(asg_b_i) + rp_types_pkg::dac_sum_t'(pid_b_i);

  assign dac_code_a_o = sat_inv(sum_a);
  assign dac_code_b_o = sat_inv(sum_b);

  ////////////////////////////////////////////////////////////////////////////
  // output pipeline
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_a_q     <= '0;
      dac_b_q     <= '0;
      dac_dat_a_o <= '0;
      dac_dat_b_o <= '0;
    end
    else
    begin
      dac_a_q     <= dac_code_a_o;
      dac_b_q     <= dac_code_b_o;
      dac_dat_a_o <= dac_b_q; // ch b -> dac a
      dac_dat_b_o <= dac_a_q; // ch a -> dac b
    end
  end

  // dac reset follows core reset one cycle late
  always_ff @(posedge adc_clk)
    dac_reset_o <= !rst_n_i;

endmodule

// ==== hdl/rp_adc_capture.sv ====
/*
 * ADC capture. Registers both raw channels, then crosses them and clears
 * the two low bits, or feeds the DAC codes back when loopback is on.
 */

`timescale 1ns/1ps

module rp_adc_capture (
  input  logic                      adc_clk,
  input  logic                      rst_n_i,
  input  rp_types_pkg::adc_sample_t adc_a_i,      // raw channel a
  input  rp_types_pkg::adc_sample_t adc_b_i,      // raw channel b
  input  rp_types_pkg::dac_code_t   dac_code_a_i, // loopback source a
  input  rp_types_pkg::dac_code_t   dac_code_b_i, // loopback source b
  input  logic                      loop_en_i,    // digital loopback
  output rp_types_pkg::adc_sample_t adc_ch_a_o,
  output rp_types_pkg::adc_sample_t adc_ch_b_o
);

  rp_types_pkg::adc_sample_t adc_a_q; // input register, stands in for iddr
  rp_types_pkg::adc_sample_t adc_b_q;

  // first stage straight from the pins
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      adc_a_q <= '0;
      adc_b_q <= '0;
    end
    else
    begin
      adc_a_q <= adc_a_i;
      adc_b_q <= adc_b_i;
    end
  end

  // switch stage, channels cross here
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      adc_ch_a_o <= '0;
      adc_ch_b_o <= '0;
    end
    else if (loop_en_i)
    begin
      adc_ch_a_o <= rp_types_pkg::adc_sample_t'(dac_code_a_i); // dac a -> ch a
      adc_ch_b_o <= rp_types_pkg::adc_sample_t'(dac_code_b_i);
    end
    else
    begin
      adc_ch_a_o <= {adc_b_q[13:2], 2'b00}; // adc b -> ch a, lsbs dropped
      adc_ch_b_o <= {adc_a_q[13:2], 2'b00}; // adc a -> ch b
    end
  end

endmodule

// ==== hdl/rp_regmap_pkg.sv ====
/*
 * Register map of the analog core.
 * Bus region numbering and the offsets inside the register block.
 */

package rp_regmap_pkg;

  // bus split
  localparam int unsigned n_regions = 8;
  localparam logic [$clog2(n_regions)-1:0] regs_region = '0; // register block

  ////////////////////////////////////////////////////////////////////////////
  // register offsets inside region 0
  ////////////////////////////////////////////////////////////////////////////

  localparam rp_types_pkg::sys_addr_t ctrl_ofs = 32'h0000_0000; // bit0 loopback
  localparam rp_types_pkg::sys_addr_t id_ofs   = 32'h0000_0004; // read only
  localparam rp_types_pkg::sys_addr_t adc_ofs  = 32'h0000_0008; // {ch_b, ch_a}

  // identification word
  localparam rp_types_pkg::sys_data_t core_id = 32'h5250_0A01;

endpackage

// ==== hdl/rp_types_pkg.sv ====
/*
 * Core vector types shared by the analog datapath and the system bus.
 * ADC samples are 14-bit two's complement, DAC codes are raw 14-bit words
 * for the negative-slope converter.
 */

package rp_types_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned adc_w = 14;        // converter resolution
  localparam int unsigned sum_w = adc_w + 1; // one guard bit for the mixer

  typedef logic signed [adc_w-1:0] adc_sample_t; // signed sample
  typedef logic        [adc_w-1:0] dac_code_t;   // raw DAC word, inverted
  typedef logic signed [sum_w-1:0] dac_sum_t;    // asg + pid, pre saturation

  ////////////////////////////////////////////////////////////////////////////
  // system bus
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned bus_w = 32;

  typedef logic [bus_w-1:0] sys_addr_t; // byte address
  typedef logic [bus_w-1:0] sys_data_t; // read/write word

endpackage
